/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_rob, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rob -Mdir obj_dir -f sim.f
	./obj_dir/Vtb_rob | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/rob_macros.svh */
////////////////////////////////////////
// depth and field widths of the reorder
// buffer, pulled in by the package and
// by any RTL block that sizes storage
////////////////////////////////////////

`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// entry count, must stay a power of two
`define ROB_DEPTH     8
// index width, log2 of the depth
`define ROB_LOG_DEPTH 3

// architectural and physical register tags
`define ARCH_TAG_W    5
`define PHYS_TAG_W    6

// fetch address width
`define PC_W          32

`endif

/* sim.f */
+incdir+include
src/rob_pkg.sv
src/rob_entry_array.sv
src/rob_pointers.sv
src/rob_control.sv
src/rob_top.sv
testbench/rob_assertions.sv
testbench/tb_rob.sv

/* src/rob_control.sv */
////////////////////////////////////////
// reorder buffer control FSM
// retire from head, restart arbitration
// by age, the backward revert walk over
// younger entries, and the halt latch
////////////////////////////////////////

`timescale 1ns/1ps

module rob_control import rob_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  rob_dispatch_t dispatch_in,
    input  rob_ptr_t      head,
    input  rob_ptr_t      tail,
    input  logic          full,
    input  logic          empty,
    input  rob_entry_t    head_entry,
    input  rob_entry_t    tail_entry,
    input  rob_restart_t  bru_restart,
    // pointer and array commands
    output logic          push,
    output logic          pop,
    output logic          step_back,
    output logic          load_tail,
    output rob_ptr_t      load_tail_value,
    output logic          invalidate_en,
    output rob_index_t    invalidate_index,
    output rob_index_t    tail_read_index,
    // outgoing buses
    output rob_retire_t   retire,
    output rob_revert_t   revert,
    output rob_kill_t     kill,
    output rob_redirect_t fetch_redirect,
    output logic          revert_stall,
    output logic          halt
);

    rob_state_t state, next_state;
    // branch that owns the current walk
    rob_index_t restart_index, next_restart_index;
    logic       halt_q, next_halt;

    logic       head_ready;
    logic       take_restart;
    logic       walk_done;
    rob_index_t target_index;

    // distance from head, smaller is older
    function automatic rob_index_t age(input rob_index_t idx, input rob_index_t head_idx);
        return idx - head_idx;
    endfunction

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state         <= ST_IDLE;
            restart_index <= '0;
            halt_q        <= 1'b0;
        end else begin
            state         <= next_state;
            restart_index <= next_restart_index;
            halt_q        <= next_halt;
        end
    end

    // walk stops at the slot after the branch
    assign target_index    = restart_index + rob_index_t'(1);
    assign walk_done       = (tail.index == target_index);
    assign head_ready      = head_entry.valid && head_entry.complete && !empty;
    // tail sits on the youngest entry while walking
    assign tail_read_index = tail.index;
    assign revert_stall    = (state == ST_REVERT);
    assign halt            = halt_q;

    always_comb begin
        next_state         = state;
        next_restart_index = restart_index;
        next_halt          = halt_q;
        take_restart       = 1'b0;
        push               = 1'b0;
        pop                = 1'b0;
        step_back          = 1'b0;
        load_tail          = 1'b0;
        load_tail_value    = rob_ptr_t'(tail - ROB_PTR_ONE);
        invalidate_en      = 1'b0;
        invalidate_index   = head.index;

        // bus fields follow their source, valids low
        retire.valid     = 1'b0;
        retire.index     = head.index;
        retire.reg_write = head_entry.reg_write;
        retire.free_tag  = head_entry.safe_tag;
        retire.is_load   = head_entry.is_load;
        retire.is_store  = head_entry.is_store;
        revert.valid     = 1'b0;
        revert.index     = tail.index;
        revert.arch_tag  = tail_entry.arch_tag;
        revert.safe_tag  = tail_entry.safe_tag;
        revert.spec_tag  = tail_entry.spec_tag;
        kill.valid       = 1'b0;
        kill.index       = tail.index;

        case (state)
            ////////////////////////////////////////
            ST_IDLE: begin
                // in-order retire
                if (head_ready) begin
                    pop              = 1'b1;
                    retire.valid     = 1'b1;
                    invalidate_en    = 1'b1;
                    invalidate_index = head.index;
                    if (head_entry.is_halt) begin
                        next_state = ST_HALT;
                        next_halt  = 1'b1;
                    end
                end
                // a retiring halt outranks a restart
                take_restart = bru_restart.valid && !(head_ready && head_entry.is_halt);
                if (take_restart) begin
                    next_restart_index = bru_restart.index;
                    // walk only if something is younger than the branch
                    if (tail.index != bru_restart.index + rob_index_t'(1)) begin
                        next_state = ST_REVERT;
                        load_tail  = 1'b1;
                    end
                end
                // wrong-path dispatch is dropped on a restart
                push = dispatch_in.valid && !full && !take_restart;
            end
            ////////////////////////////////////////
            ST_REVERT: begin
                // youngest remaining entry goes this cycle
                invalidate_en    = 1'b1;
                invalidate_index = tail.index;
                kill.valid       = tail_entry.valid;
                revert.valid     = tail_entry.valid && tail_entry.reg_write;
                // only an older branch takes over
                take_restart = bru_restart.valid &&
                               (age(bru_restart.index, head.index) <
                                age(restart_index, head.index));
                if (take_restart) begin
                    next_restart_index = bru_restart.index;
                    step_back          = 1'b1;
                end else if (walk_done) begin
                    next_state = ST_IDLE;
                end else begin
                    step_back = 1'b1;
                end
            end
            // stopped for good
            ST_HALT: begin
                next_state = ST_HALT;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase

        fetch_redirect.valid = take_restart;
        fetch_redirect.pc    = bru_restart.pc;
    end

endmodule

/* src/rob_entry_array.sv */
////////////////////////////////////////
// reorder buffer entry storage
// dispatch writes, completion marks and
// invalidates land on the clock edge;
// head and walk entries read out comb
////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_macros.svh"

module rob_entry_array import rob_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    // dispatch at tail
    input  logic          write_en,
    input  rob_index_t    write_index,
    input  rob_dispatch_t write_data,
    // completion buses
    input  rob_complete_t alu_complete,
    input  rob_complete_t bru_complete,
    // retire or walk drops an entry
    input  logic          invalidate_en,
    input  rob_index_t    invalidate_index,
    // read ports
    input  rob_index_t    head_index,
    input  rob_index_t    tail_read_index,
    output rob_entry_t    head_entry,
    output rob_entry_t    tail_entry
);

    // status bits per entry
    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] complete_q;
    // instruction fields, written once at dispatch
    rob_dispatch_t         payload_q [`ROB_DEPTH];

    // bus hits a live entry
    function automatic logic marks(input rob_complete_t c, input rob_index_t idx,
                                   input logic live);
        return live && c.valid && (c.index == idx);
    endfunction

    // status bits plus stored fields
    function automatic rob_entry_t build_entry(input logic v, input logic c,
                                               input rob_dispatch_t p);
        rob_entry_t e;
        e.valid     = v;
        e.complete  = c;
        e.reg_write = p.reg_write;
        e.is_load   = p.is_load;
        e.is_store  = p.is_store;
        e.is_halt   = p.is_halt;
        e.arch_tag  = p.arch_tag;
        e.safe_tag  = p.safe_tag;
        e.spec_tag  = p.spec_tag;
        return e;
    endfunction

    ////////////////////////////////////////
    // status update

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (write_en && (write_index == rob_index_t'(i))) begin
                    // fresh entry, not done yet
                    valid_q[i]    <= 1'b1;
                    complete_q[i] <= 1'b0;
                end else begin
                    if (invalidate_en && (invalidate_index == rob_index_t'(i))) begin
                        valid_q[i] <= 1'b0;
                    end
                    // completions to dead entries are dropped
                    if (marks(alu_complete, rob_index_t'(i), valid_q[i]) ||
                        marks(bru_complete, rob_index_t'(i), valid_q[i])) begin
                        complete_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        if (write_en) begin
            payload_q[write_index] <= write_data;
        end
    end

    ////////////////////////////////////////
    // read ports

    assign head_entry = build_entry(valid_q[head_index], complete_q[head_index],
                                    payload_q[head_index]);
    assign tail_entry = build_entry(valid_q[tail_read_index], complete_q[tail_read_index],
                                    payload_q[tail_read_index]);

endmodule

/* src/rob_pkg.sv */
////////////////////////////////////////
// types shared by the reorder buffer
// blocks: pointers, entry layout and the
// single-cycle bus structs at the edges
////////////////////////////////////////

`include "rob_macros.svh"

package rob_pkg;

    typedef logic [`ROB_LOG_DEPTH-1:0] rob_index_t;
    typedef logic [`ARCH_TAG_W-1:0]    arch_tag_t;
    typedef logic [`PHYS_TAG_W-1:0]    phys_tag_t;
    typedef logic [`PC_W-1:0]          pc_t;

    // wrap bit separates full from empty
    typedef struct packed {
        logic       wrap;
        rob_index_t index;
    } rob_ptr_t;

    // one step of a pointer
    localparam rob_ptr_t ROB_PTR_ONE = '{wrap: 1'b0, index: rob_index_t'(1)};

    // from the dispatch unit
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
        logic      is_halt;
        arch_tag_t arch_tag;
        // old mapping, freed at retire
        phys_tag_t safe_tag;
        // new mapping, undone on revert
        phys_tag_t spec_tag;
    } rob_dispatch_t;

    typedef struct packed {
        logic      valid;
        logic      complete;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
        logic      is_halt;
        arch_tag_t arch_tag;
        phys_tag_t safe_tag;
        phys_tag_t spec_tag;
    } rob_entry_t;

    typedef struct packed {
        logic       valid;
        rob_index_t index;
    } rob_complete_t;

    typedef struct packed {
        logic       valid;
        rob_index_t index;
        pc_t        pc;
    } rob_restart_t;

    typedef struct packed {
        logic       valid;
        rob_index_t index;
        logic       reg_write;
        phys_tag_t  free_tag;
        logic       is_load;
        logic       is_store;
    } rob_retire_t;

    typedef struct packed {
        logic       valid;
        rob_index_t index;
        arch_tag_t  arch_tag;
        phys_tag_t  safe_tag;
        phys_tag_t  spec_tag;
    } rob_revert_t;

    typedef struct packed {
        logic       valid;
        rob_index_t index;
    } rob_kill_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } rob_redirect_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REVERT,
        ST_HALT
    } rob_state_t;

endpackage

/* src/rob_pointers.sv */
////////////////////////////////////////
// head and tail pointers with wrap bits
// commands come from the control block;
// full and empty are registered from
// the next pointer values
////////////////////////////////////////

`timescale 1ns/1ps

module rob_pointers import rob_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    // tail advances on dispatch
    input  logic     push,
    // head advances on retire
    input  logic     pop,
    // tail moves back one during the walk
    input  logic     step_back,
    // tail jump on a restart
    input  logic     load_tail,
    input  rob_ptr_t load_tail_value,
    output rob_ptr_t head,
    output rob_ptr_t tail,
    output logic     full,
    output logic     empty
);

    rob_ptr_t next_head;
    rob_ptr_t next_tail;
    logic     next_full;
    logic     next_empty;

    ////////////////////////////////////////
    // next pointers

    always_comb begin
        next_head = head;
        next_tail = tail;
        if (pop) begin
            next_head = rob_ptr_t'(head + ROB_PTR_ONE);
        end
        // restart load beats the walk step, walk beats dispatch
        if (load_tail) begin
            next_tail = load_tail_value;
        end else if (step_back) begin
            next_tail = rob_ptr_t'(tail - ROB_PTR_ONE);
        end else if (push) begin
            next_tail = rob_ptr_t'(tail + ROB_PTR_ONE);
        end
    end

    // same slot, same lap means empty
    assign next_empty = (next_head == next_tail);
    // same slot, other lap means full
    assign next_full  = (next_head.index == next_tail.index) &&
                        (next_head.wrap != next_tail.wrap);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head  <= '0;
            tail  <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            head  <= next_head;
            tail  <= next_tail;
            full  <= next_full;
            empty <= next_empty;
        end
    end

endmodule

/* src/rob_top.sv */
////////////////////////////////////////
// reorder buffer top level
// ties entry storage, pointers and the
// control FSM together
////////////////////////////////////////

`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  rob_dispatch_t dispatch_in,
    input  rob_complete_t alu_complete,
    input  rob_complete_t bru_complete,
    input  rob_restart_t  bru_restart,
    output rob_index_t    dispatch_index,
    output logic          full,
    output logic          empty,
    output rob_retire_t   retire,
    output rob_revert_t   revert,
    output rob_kill_t     kill,
    output rob_redirect_t fetch_redirect,
    output logic          revert_stall,
    output logic          halt
);

    // pointer commands
    logic       push;
    logic       pop;
    logic       step_back;
    logic       load_tail;
    rob_ptr_t   load_tail_value;
    rob_ptr_t   head;
    rob_ptr_t   tail;
    // array commands and reads
    logic       invalidate_en;
    rob_index_t invalidate_index;
    rob_index_t tail_read_index;
    rob_entry_t head_entry;
    rob_entry_t tail_entry;

    // next dispatch lands at the tail
    assign dispatch_index = tail.index;

    rob_entry_array u_array (
        .CLK              (CLK),
        .nRST             (nRST),
        .write_en         (push),
        .write_index      (tail.index),
        .write_data       (dispatch_in),
        .alu_complete     (alu_complete),
        .bru_complete     (bru_complete),
        .invalidate_en    (invalidate_en),
        .invalidate_index (invalidate_index),
        .head_index       (head.index),
        .tail_read_index  (tail_read_index),
        .head_entry       (head_entry),
        .tail_entry       (tail_entry)
    );

    rob_pointers u_pointers (
        .CLK             (CLK),
        .nRST            (nRST),
        .push            (push),
        .pop             (pop),
        .step_back       (step_back),
        .load_tail       (load_tail),
        .load_tail_value (load_tail_value),
        .head            (head),
        .tail            (tail),
        .full            (full),
        .empty           (empty)
    );

    rob_control u_control (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_in      (dispatch_in),
        .head             (head),
        .tail             (tail),
        .full             (full),
        .empty            (empty),
        .head_entry       (head_entry),
        .tail_entry       (tail_entry),
        .bru_restart      (bru_restart),
        .push             (push),
        .pop              (pop),
        .step_back        (step_back),
        .load_tail        (load_tail),
        .load_tail_value  (load_tail_value),
        .invalidate_en    (invalidate_en),
        .invalidate_index (invalidate_index),
        .tail_read_index  (tail_read_index),
        .retire           (retire),
        .revert           (revert),
        .kill             (kill),
        .fetch_redirect   (fetch_redirect),
        .revert_stall     (revert_stall),
        .halt             (halt)
    );

endmodule

/* testbench/rob_assertions.sv */
////////////////////////////////////////
// protocol properties on the reorder
// buffer outputs, bound into rob_top
////////////////////////////////////////

`timescale 1ns/1ps

module rob_assertions import rob_pkg::*; (
    input logic        CLK,
    input logic        nRST,
    input logic        full,
    input logic        empty,
    input logic        revert_stall,
    input logic        halt,
    input rob_retire_t retire,
    input rob_kill_t   kill
);

    // pointer flags exclusive
    full_excl_empty: assert property (@(posedge CLK) disable iff (!nRST) !(full && empty))
        else $error("full and empty are high together");

    // nothing to retire from an empty buffer
    retire_not_empty: assert property (@(posedge CLK) disable iff (!nRST)
        !(retire.valid && empty))
        else $error("retire while the buffer is empty");

    // walk owns the buffer
    retire_not_walk: assert property (@(posedge CLK) disable iff (!nRST)
        !(retire.valid && revert_stall))
        else $error("retire during the revert walk");

    kill_excl_retire: assert property (@(posedge CLK) disable iff (!nRST)
        !(kill.valid && retire.valid))
        else $error("kill and retire in the same cycle");

    // halt is sticky
    halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
        else $error("halt dropped after it was set");

endmodule

bind rob_top rob_assertions u_assertions (
    .CLK          (CLK),
    .nRST         (nRST),
    .full         (full),
    .empty        (empty),
    .revert_stall (revert_stall),
    .halt         (halt),
    .retire       (retire),
    .kill         (kill)
);

/* testbench/tb_rob.sv */
////////////////////////////////////////
// directed testbench for the reorder
// buffer covering fill, retire fields,
// branch restarts and halt with one
// task per test
////////////////////////////////////////

`timescale 1ns/1ps

`include "rob_macros.svh"

module tb_rob import rob_pkg::*; ();

    localparam int WAIT_LIMIT = 8 * `ROB_DEPTH;

    logic          CLK;
    logic          nRST;
    rob_dispatch_t dispatch_in;
    rob_complete_t alu_complete;
    rob_complete_t bru_complete;
    rob_restart_t  bru_restart;
    rob_index_t    dispatch_index;
    logic          full;
    logic          empty;
    rob_retire_t   retire;
    rob_revert_t   revert;
    rob_kill_t     kill;
    rob_redirect_t fetch_redirect;
    logic          revert_stall;
    logic          halt;

    // bookkeeping
    string         current_test;
    int            errors;
    int            test_errors;
    int            checks;
    int            tests_run;
    logic [31:0]   lfsr_state;
    rob_dispatch_t ops [`ROB_DEPTH];

    // bus traffic seen by the monitor
    rob_retire_t   retire_log[$];
    rob_revert_t   revert_log[$];
    rob_kill_t     kill_log[$];
    rob_redirect_t redirect_log[$];

    rob_top u_dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_in    (dispatch_in),
        .alu_complete   (alu_complete),
        .bru_complete   (bru_complete),
        .bru_restart    (bru_restart),
        .dispatch_index (dispatch_index),
        .full           (full),
        .empty          (empty),
        .retire         (retire),
        .revert         (revert),
        .kill           (kill),
        .fetch_redirect (fetch_redirect),
        .revert_stall   (revert_stall),
        .halt           (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // bus monitor samples at the falling edge
    always @(negedge CLK) begin
        if (nRST) begin
            if (retire.valid) retire_log.push_back(retire);
            if (revert.valid) revert_log.push_back(revert);
            if (kill.valid) kill_log.push_back(kill);
            if (fetch_redirect.valid) redirect_log.push_back(fetch_redirect);
        end
    end

    ////////////////////////////////////////
    // helpers

    // galois form with taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int b = 0; b < n; b++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic rob_dispatch_t make_op(input logic rw, input logic ld, input logic st,
                                              input logic hl, input arch_tag_t arch,
                                              input phys_tag_t safe, input phys_tag_t spec);
        return '{valid: 1'b1, reg_write: rw, is_load: ld, is_store: st, is_halt: hl,
                 arch_tag: arch, safe_tag: safe, spec_tag: spec};
    endfunction

    // retire frees the old mapping
    function automatic rob_retire_t expect_retire(input int idx, input rob_dispatch_t op);
        return '{valid: 1'b1, index: rob_index_t'(idx), reg_write: op.reg_write,
                 free_tag: op.safe_tag, is_load: op.is_load, is_store: op.is_store};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("mismatch in %s, %s: expected %0h, actual %0h",
                     current_test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", current_test, msg);
        errors++;
        test_errors++;
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic clear_inputs();
        dispatch_in  = '0;
        alu_complete = '0;
        bru_complete = '0;
        bru_restart  = '0;
    endtask

    task automatic apply_reset();
        nRST = 1'b0;
        clear_inputs();
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        apply_reset();
        retire_log.delete();
        revert_log.delete();
        kill_log.delete();
        redirect_log.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) $display("test %s: ok", current_test);
        else $display("test %s: %0d errors", current_test, test_errors);
    endtask

    task automatic dispatch_one(input rob_dispatch_t op);
        dispatch_in = op;
        next_cycle();
        dispatch_in = '0;
    endtask

    // negative index leaves that bus idle
    task automatic send_completions(input int alu_idx, input int bru_idx);
        alu_complete = '{valid: alu_idx >= 0, index: rob_index_t'(alu_idx)};
        bru_complete = '{valid: bru_idx >= 0, index: rob_index_t'(bru_idx)};
        next_cycle();
        alu_complete = '0;
        bru_complete = '0;
    endtask

    task automatic restart_branch(input int idx, input pc_t pc);
        bru_restart = '{valid: 1'b1, index: rob_index_t'(idx), pc: pc};
        next_cycle();
        bru_restart = '0;
    endtask

    ////////////////////////////////////////
    // bounded waits

    task automatic wait_empty();
        int n;
        n = 0;
        while (!empty && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!empty) report_failure("buffer did not drain before the timeout");
    endtask

    task automatic wait_halt();
        int n;
        n = 0;
        while (!halt && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!halt) report_failure("halt did not rise before the timeout");
    endtask

    task automatic count_stall(output int cycles);
        cycles = 0;
        while (revert_stall && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (revert_stall) report_failure("revert walk did not end before the timeout");
    endtask

    ////////////////////////////////////////
    // log checks

    task automatic check_retires(input int n);
        check_value("retire count", 64'(n), 64'(retire_log.size()));
        for (int k = 0; k < n && k < retire_log.size(); k++) begin
            check_value("retire", 64'(expect_retire(k, ops[k])), 64'(retire_log[k]));
        end
    endtask

    // youngest first
    task automatic check_kills(input int from, input int to);
        rob_kill_t exp;
        check_value("kill count", 64'(from - to + 1), 64'(kill_log.size()));
        for (int k = 0; k <= from - to && k < kill_log.size(); k++) begin
            exp = '{valid: 1'b1, index: rob_index_t'(from - k)};
            check_value("kill", 64'(exp), 64'(kill_log[k]));
        end
    endtask

    ////////////////////////////////////////
    // tests

    task automatic fill_backpressure_order();
        int order [`ROB_DEPTH];
        int pick;
        int tmp;
        begin_test("fill_order");
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            ops[i] = make_op(i[0], 1'b0, 1'b0, 1'b0, arch_tag_t'(i),
                             phys_tag_t'(i + 1), phys_tag_t'(i + 32));
        end
        // last pass pushes against a full buffer
        for (int i = 0; i <= `ROB_DEPTH; i++) begin
            check_value("full", 64'(i == `ROB_DEPTH), 64'(full));
            check_value("dispatch index", 64'(i % `ROB_DEPTH), 64'(dispatch_index));
            if (i < `ROB_DEPTH) dispatch_one(ops[i]);
            else dispatch_one(make_op(1'b1, 1'b1, 1'b1, 1'b0, 5'd31, 6'd63, 6'd63));
        end
        check_value("full after ignored dispatch", 64'(1), 64'(full));
        check_value("index after ignored dispatch", 64'(0), 64'(dispatch_index));
        // shuffled completion order
        for (int i = 0; i < `ROB_DEPTH; i++) order[i] = i;
        for (int k = `ROB_DEPTH - 1; k > 0; k--) begin
            take_bits(3, pick);
            pick        = pick % (k + 1);
            tmp         = order[k];
            order[k]    = order[pick];
            order[pick] = tmp;
        end
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            if (k[0]) send_completions(-1, order[k]);
            else send_completions(order[k], -1);
        end
        wait_empty();
        check_retires(`ROB_DEPTH);
        check_value("empty", 64'(1), 64'(empty));
        end_test();
    endtask

    task automatic retire_fields();
        begin_test("retire_fields");
        ops[0] = make_op(1'b1, 1'b1, 1'b0, 1'b0, 5'd3, 6'd10, 6'd40);
        ops[1] = make_op(1'b0, 1'b0, 1'b1, 1'b0, 5'd7, 6'd11, 6'd41);
        ops[2] = make_op(1'b1, 1'b0, 1'b0, 1'b0, 5'd9, 6'd12, 6'd42);
        ops[3] = make_op(1'b0, 1'b1, 1'b0, 1'b0, 5'd1, 6'd13, 6'd43);
        for (int k = 0; k < 4; k++) dispatch_one(ops[k]);
        // youngest complete first
        send_completions(3, 2);
        send_completions(1, 0);
        wait_empty();
        check_retires(4);
        end_test();
    endtask

    task automatic branch_restart_walk();
        int            cycles;
        rob_revert_t   exp_reverts[$];
        rob_revert_t   exp_revert;
        rob_redirect_t exp_redirect;
        begin_test("branch_restart");
        for (int k = 0; k < 6; k++) begin
            ops[k] = make_op(k != 3, 1'b0, 1'b0, 1'b0, arch_tag_t'(k + 4),
                             phys_tag_t'(k + 16), phys_tag_t'(k + 48));
            dispatch_one(ops[k]);
        end
        restart_branch(1, 32'h0000_4a10);
        count_stall(cycles);
        check_value("stall cycles", 64'(4), 64'(cycles));
        exp_redirect = '{valid: 1'b1, pc: 32'h0000_4a10};
        check_value("redirect count", 64'(1), 64'(redirect_log.size()));
        if (redirect_log.size() > 0) begin
            check_value("redirect", 64'(exp_redirect), 64'(redirect_log[0]));
        end
        check_kills(5, 2);
        // only register writers are reverted
        for (int k = 5; k >= 2; k--) begin
            if (ops[k].reg_write) begin
                exp_revert = '{valid: 1'b1, index: rob_index_t'(k),
                               arch_tag: ops[k].arch_tag, safe_tag: ops[k].safe_tag,
                               spec_tag: ops[k].spec_tag};
                exp_reverts.push_back(exp_revert);
            end
        end
        check_value("revert count", 64'(exp_reverts.size()), 64'(revert_log.size()));
        for (int k = 0; k < exp_reverts.size() && k < revert_log.size(); k++) begin
            check_value("revert", 64'(exp_reverts[k]), 64'(revert_log[k]));
        end
        check_value("dispatch index", 64'(2), 64'(dispatch_index));
        end_test();
    endtask

    task automatic older_restart_preempts();
        int cycles;
        begin_test("older_restart");
        for (int k = 0; k < 7; k++) begin
            ops[k] = make_op(1'b1, 1'b0, 1'b0, 1'b0, arch_tag_t'(k), phys_tag_t'(k),
                             phys_tag_t'(k + 8));
            dispatch_one(ops[k]);
        end
        restart_branch(4, 32'h0000_8000);
        check_value("stall after first restart", 64'(1), 64'(revert_stall));
        next_cycle();
        // older branch arrives mid-walk
        check_value("stall before second restart", 64'(1), 64'(revert_stall));
        restart_branch(1, 32'h0000_9004);
        count_stall(cycles);
        check_value("stall cycles", 64'(5), 64'(cycles + 2));
        check_value("redirect count", 64'(2), 64'(redirect_log.size()));
        if (redirect_log.size() > 1) check_value("second redirect pc", 64'(32'h0000_9004),
                                                 64'(redirect_log[1].pc));
        check_kills(6, 2);
        check_value("dispatch index", 64'(2), 64'(dispatch_index));
        end_test();
    endtask

    task automatic halt_stops_buffer();
        begin_test("halt");
        ops[0] = make_op(1'b1, 1'b0, 1'b0, 1'b0, 5'd2, 6'd20, 6'd30);
        ops[1] = make_op(1'b0, 1'b0, 1'b0, 1'b1, 5'd0, 6'd21, 6'd31);
        ops[2] = make_op(1'b1, 1'b0, 1'b1, 1'b0, 5'd4, 6'd22, 6'd32);
        for (int k = 0; k < 3; k++) dispatch_one(ops[k]);
        send_completions(0, 1);
        send_completions(2, -1);
        wait_halt();
        // later traffic must go nowhere
        dispatch_one(make_op(1'b1, 1'b0, 1'b0, 1'b0, 5'd5, 6'd23, 6'd33));
        send_completions(2, 3);
        repeat (8) next_cycle();
        check_retires(2);
        check_value("halt", 64'(1), 64'(halt));
        check_value("dispatch index", 64'(3), 64'(dispatch_index));
        end_test();
    endtask

    ////////////////////////////////////////
    // sequence

    initial begin
        nRST        = 1'b0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        lfsr_state  = 32'hc914_4626;
        clear_inputs();
        fill_backpressure_order();
        retire_fields();
        branch_restart_walk();
        older_restart_preempts();
        halt_stops_buffer();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
